// ==== logic/apb_bus_pkg.sv ====
// **********************************************************
// APB bus widths, data types and the register address map
// Imported by the slave port and the testbench
// **********************************************************

package apb_bus_pkg;

  // **********************************************************
  // Bus widths
  // **********************************************************
  // Three address bits cover the eight register slots
  localparam int APB_ADDR_WIDTH = 3;
  // Byte wide data path
  localparam int APB_DATA_WIDTH = 8;

  // Bus address and data types
  typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

  // **********************************************************
  // Register address map
  // **********************************************************
  // Data status, bit 0 is data ready (read only)
  localparam apb_addr_t ADDR_DATA_SR  = 3'd0;
  // Error status code (read only)
  localparam apb_addr_t ADDR_ERROR_SR = 3'd1;
  // Bit period, low byte
  localparam apb_addr_t ADDR_BIT_CR0  = 3'd2;
  // Bit period, upper six bits
  localparam apb_addr_t ADDR_BIT_CR1  = 3'd3;
  // Data bits per frame
  localparam apb_addr_t ADDR_DATA_CR  = 3'd4;
  // Received byte, reading it acknowledges the UART
  localparam apb_addr_t ADDR_RX_DATA  = 3'd6;

  // Slots 5 and 7 are left unmapped and answer with a slave error

endpackage

// ==== logic/uart_cfg_pkg.sv ====
// **********************************************************
// UART configuration and status types with reset defaults
// Shared by the register block and the testbench model
// **********************************************************

package uart_cfg_pkg;

  // Field widths
  localparam int BIT_PERIOD_WIDTH    = 14;
  localparam int BIT_PERIOD_LO_WIDTH = 8;
  localparam int BIT_PERIOD_HI_WIDTH = BIT_PERIOD_WIDTH - BIT_PERIOD_LO_WIDTH;
  localparam int DATA_SIZE_WIDTH     = 4;
  localparam int RX_DATA_WIDTH       = 8;
  localparam int ERR_CODE_WIDTH      = 2;

  // Bit period in clock cycles
  typedef logic [BIT_PERIOD_WIDTH-1:0] bit_period_t;
  // Data bits per frame
  typedef logic [DATA_SIZE_WIDTH-1:0]  data_size_t;
  // Received byte
  typedef logic [RX_DATA_WIDTH-1:0]    rx_data_t;
  // Error status code
  typedef logic [ERR_CODE_WIDTH-1:0]   err_code_t;

  // Error codes, framing wins when both flags are set
  localparam err_code_t ERR_NONE    = 2'd0;
  localparam err_code_t ERR_FRAMING = 2'd1;
  localparam err_code_t ERR_OVERRUN = 2'd2;

  // Reset defaults for the configuration registers
  localparam bit_period_t DEFAULT_BIT_PERIOD = 14'd10;
  localparam data_size_t  DEFAULT_DATA_SIZE  = 4'd8;

endpackage

// ==== logic/apb_slave_port.sv ====
// **********************************************************
// APB slave front end, purely combinational
// Decodes each access cycle into register strobes or a slave
// error and muxes the read data back onto prdata
// **********************************************************

module apb_slave_port
  import apb_bus_pkg::*;
  import uart_cfg_pkg::*;
(
  // APB request
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  // Register contents for read back
  input  bit_period_t bit_period,
  input  data_size_t  data_size,
  input  rx_data_t    rx_data_q,
  input  logic        data_ready_q,
  input  err_code_t   err_code,
  // APB response
  output apb_data_t   prdata,
  output logic        pslverr,
  // One-cycle strobes toward the registers
  output logic        wr_bit_lo,
  output logic        wr_bit_hi,
  output logic        wr_data_size,
  output logic        rx_read
);

  logic      access;
  logic      rd_map;
  logic      wr_map;
  logic      rd_ok;
  logic      wr_ok;
  apb_data_t rd_mux;

  // **********************************************************
  // Address decode
  // **********************************************************
  // Which slots accept a read and which accept a write
  always_comb begin
    rd_map = 1'b0;
    wr_map = 1'b0;
    case (paddr)
      // Status and data are read only
      ADDR_DATA_SR, ADDR_ERROR_SR, ADDR_RX_DATA: begin
        rd_map = 1'b1;
      end
      // Configuration takes both directions
      ADDR_BIT_CR0, ADDR_BIT_CR1, ADDR_DATA_CR: begin
        rd_map = 1'b1;
        wr_map = 1'b1;
      end
      // Unmapped slots
      default: begin
        rd_map = 1'b0;
        wr_map = 1'b0;
      end
    endcase
  end

  // Second cycle of the transfer, no wait states
  assign access = psel & penable;
  assign rd_ok  = access & ~pwrite & rd_map;
  assign wr_ok  = access & pwrite & wr_map;

  // Anything else in an access cycle is refused
  assign pslverr = access & ~(rd_ok | wr_ok);

  // Write strobes, one per configuration field
  assign wr_bit_lo    = wr_ok & (paddr == ADDR_BIT_CR0);
  assign wr_bit_hi    = wr_ok & (paddr == ADDR_BIT_CR1);
  assign wr_data_size = wr_ok & (paddr == ADDR_DATA_CR);

  // Receive data read, turned into data_read downstream
  assign rx_read = rd_ok & (paddr == ADDR_RX_DATA);

  // **********************************************************
  // Read data mux
  // **********************************************************
  always_comb begin
    case (paddr)
      ADDR_DATA_SR:  rd_mux = apb_data_t'(data_ready_q);
      ADDR_ERROR_SR: rd_mux = apb_data_t'(err_code);
      ADDR_BIT_CR0:  rd_mux = bit_period[BIT_PERIOD_LO_WIDTH-1:0];
      // Upper bits, zero extended to the bus width
      ADDR_BIT_CR1:  rd_mux = apb_data_t'(bit_period[BIT_PERIOD_WIDTH-1:BIT_PERIOD_LO_WIDTH]);
      ADDR_DATA_CR:  rd_mux = apb_data_t'(data_size);
      ADDR_RX_DATA:  rd_mux = rx_data_q;
      default:       rd_mux = '0;
    endcase
  end

  // Zero outside a legal read access
  assign prdata = rd_ok ? rd_mux : '0;

endmodule

// ==== logic/uart_config_regs.sv ====
// **********************************************************
// UART configuration registers
// Bit period in two byte-wide halves plus the data size,
// loaded from pwdata on the slave port's write strobes
// **********************************************************

module uart_config_regs
  import apb_bus_pkg::*;
  import uart_cfg_pkg::*;
#(
  parameter bit_period_t RESET_BIT_PERIOD = DEFAULT_BIT_PERIOD,
  parameter data_size_t  RESET_DATA_SIZE  = DEFAULT_DATA_SIZE
) (
  input  logic        tb_clk,
  input  logic        rst_n,
  // Strobes from the slave port
  input  logic        wr_bit_lo,
  input  logic        wr_bit_hi,
  input  logic        wr_data_size,
  // Write data straight from the bus
  input  apb_data_t   pwdata,
  // Configuration toward the UART and for read back
  output bit_period_t bit_period,
  output data_size_t  data_size
);

  logic [BIT_PERIOD_LO_WIDTH-1:0] bit_lo_q;
  logic [BIT_PERIOD_HI_WIDTH-1:0] bit_hi_q;
  data_size_t                     data_size_q;

  // **********************************************************
  // Bit period halves
  // **********************************************************
  // Low byte takes the full bus word
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_lo_q <= RESET_BIT_PERIOD[BIT_PERIOD_LO_WIDTH-1:0];
    end else if (wr_bit_lo) begin
      bit_lo_q <= pwdata[BIT_PERIOD_LO_WIDTH-1:0];
    end
  end

  // High half keeps only six bits, the top two bus bits are lost
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_hi_q <= RESET_BIT_PERIOD[BIT_PERIOD_WIDTH-1:BIT_PERIOD_LO_WIDTH];
    end else if (wr_bit_hi) begin
      bit_hi_q <= pwdata[BIT_PERIOD_HI_WIDTH-1:0];
    end
  end

  // **********************************************************
  // Data size
  // **********************************************************
  // Only the low nibble of the write is kept
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_size_q <= RESET_DATA_SIZE;
    end else if (wr_data_size) begin
      data_size_q <= pwdata[DATA_SIZE_WIDTH-1:0];
    end
  end

  // Halves joined back into one period
  assign bit_period = {bit_hi_q, bit_lo_q};
  assign data_size  = data_size_q;

endmodule

// ==== logic/uart_status_capture.sv ====
// **********************************************************
// UART status capture
// Samples the receiver outputs once per cycle, folds the error
// flags into one code and forms the data_read acknowledge
// **********************************************************

module uart_status_capture
  import uart_cfg_pkg::*;
(
  input  logic      tb_clk,
  input  logic      rst_n,
  // Receiver status, plain levels
  input  rx_data_t  rx_data,
  input  logic      data_ready,
  input  logic      overrun_error,
  input  logic      framing_error,
  // Legal read of the receive data register
  input  logic      rx_read,
  // Registered status for the slave port
  output rx_data_t  rx_data_q,
  output logic      data_ready_q,
  output err_code_t err_code,
  // Acknowledge toward the receiver
  output logic      data_read
);

  err_code_t err_next;

  // Framing error takes priority over overrun
  always_comb begin
    if (framing_error) begin
      err_next = ERR_FRAMING;
    end else if (overrun_error) begin
      err_next = ERR_OVERRUN;
    end else begin
      err_next = ERR_NONE;
    end
  end

  // **********************************************************
  // Status registers
  // **********************************************************
  // One cycle of latency from pin to read data
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_data_q    <= '0;
      data_ready_q <= 1'b0;
      err_code     <= ERR_NONE;
    end else begin
      rx_data_q    <= rx_data;
      data_ready_q <= data_ready;
      err_code     <= err_next;
    end
  end

  // Read strobe lasts one access cycle, so the pulse is one cycle
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_read <= 1'b0;
    end else begin
      data_read <= rx_read;
    end
  end

endmodule

// ==== logic/apb_uart_regs.sv ====
// **********************************************************
// APB register block in front of a UART receiver
// Top level, wires the slave port to the configuration
// registers and the status capture
// **********************************************************

module apb_uart_regs
  import apb_bus_pkg::*;
  import uart_cfg_pkg::*;
#(
  parameter bit_period_t RESET_BIT_PERIOD = DEFAULT_BIT_PERIOD,
  parameter data_size_t  RESET_DATA_SIZE  = DEFAULT_DATA_SIZE
) (
  input  logic        tb_clk,
  input  logic        rst_n,
  // APB slave
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  input  apb_data_t   pwdata,
  output apb_data_t   prdata,
  output logic        pslverr,
  // UART receiver side
  input  rx_data_t    rx_data,
  input  logic        data_ready,
  input  logic        overrun_error,
  input  logic        framing_error,
  output logic        data_read,
  output bit_period_t bit_period,
  output data_size_t  data_size
);

  // Strobes from the decoder
  logic      wr_bit_lo;
  logic      wr_bit_hi;
  logic      wr_data_size;
  logic      rx_read;
  // Registered receiver status
  rx_data_t  rx_data_q;
  logic      data_ready_q;
  err_code_t err_code;

  // Bus decode and read back
  apb_slave_port u_slave_port (
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .bit_period   (bit_period),
    .data_size    (data_size),
    .rx_data_q    (rx_data_q),
    .data_ready_q (data_ready_q),
    .err_code     (err_code),
    .prdata       (prdata),
    .pslverr      (pslverr),
    .wr_bit_lo    (wr_bit_lo),
    .wr_bit_hi    (wr_bit_hi),
    .wr_data_size (wr_data_size),
    .rx_read      (rx_read)
  );

  // Configuration storage
  uart_config_regs #(
    .RESET_BIT_PERIOD (RESET_BIT_PERIOD),
    .RESET_DATA_SIZE  (RESET_DATA_SIZE)
  ) u_config_regs (
    .tb_clk       (tb_clk),
    .rst_n        (rst_n),
    .wr_bit_lo    (wr_bit_lo),
    .wr_bit_hi    (wr_bit_hi),
    .wr_data_size (wr_data_size),
    .pwdata       (pwdata),
    .bit_period   (bit_period),
    .data_size    (data_size)
  );

  // Receiver status and acknowledge
  uart_status_capture u_status_capture (
    .tb_clk        (tb_clk),
    .rst_n         (rst_n),
    .rx_data       (rx_data),
    .data_ready    (data_ready),
    .overrun_error (overrun_error),
    .framing_error (framing_error),
    .rx_read       (rx_read),
    .rx_data_q     (rx_data_q),
    .data_ready_q  (data_ready_q),
    .err_code      (err_code),
    .data_read     (data_read)
  );

endmodule

// ==== bench/apb_uart_regs_checker.sv ====
// **********************************************************
// APB and data_read protocol assertions
// Bound into the register block top level
// **********************************************************

module apb_uart_regs_checker
  import apb_bus_pkg::*;
(
  input logic      tb_clk,
  input logic      rst_n,
  input logic      psel,
  input logic      penable,
  input logic      pwrite,
  input apb_addr_t paddr,
  input logic      pslverr,
  input logic      data_read
);

  // Failed assertions, summed into the testbench result
  int unsigned fail_count = 0;

  // Slave error only in the second cycle of a transfer
  a_err_in_access : assert property (@(posedge tb_clk) disable iff (!rst_n)
    pslverr |-> (psel && penable))
    else begin
      $error("pslverr raised outside an access cycle");
      fail_count++;
    end

  // Acknowledge is a single cycle
  a_pulse_single : assert property (@(posedge tb_clk) disable iff (!rst_n)
    data_read |=> !data_read)
    else begin
      $error("data_read high for two cycles in a row");
      fail_count++;
    end

  // Only a receive data read may cause it
  a_pulse_cause : assert property (@(posedge tb_clk) disable iff (!rst_n)
    data_read |-> $past(psel && penable && !pwrite && paddr == ADDR_RX_DATA))
    else begin
      $error("data_read without a preceding receive data read");
      fail_count++;
    end

endmodule

bind apb_uart_regs apb_uart_regs_checker u_checker (.*);

// ==== bench/tb_apb_uart_regs.sv ====
// **********************************************************
// Testbench for the APB UART register block
// Random APB traffic and UART status checked against a local
// model, built and run from the project root by run_sim.sh
// **********************************************************

module tb_apb_uart_regs
  import apb_bus_pkg::*;
  import uart_cfg_pkg::*;
();

  localparam int unsigned WATCHDOG_CYCLES = 20000;
  localparam int unsigned PULSE_TIMEOUT   = 8;

  logic        tb_clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pslverr;
  rx_data_t    rx_data;
  logic        data_ready;
  logic        overrun_error;
  logic        framing_error;
  logic        data_read;
  bit_period_t bit_period;
  data_size_t  data_size;

  // Model of the configuration and the registered UART status
  bit_period_t m_bit_period;
  data_size_t  m_data_size;
  rx_data_t    m_rx;
  logic        m_ready;
  err_code_t   m_err;

  logic [31:0] lcg_state;
  int unsigned value_errors;
  int unsigned timeout_errors;

  apb_uart_regs #(
    .RESET_BIT_PERIOD (DEFAULT_BIT_PERIOD),
    .RESET_DATA_SIZE  (DEFAULT_DATA_SIZE)
  ) DUT (.*);

  initial begin
    tb_clk = 1'b0;
    forever #2 tb_clk = ~tb_clk;
  end

  // **********************************************************
  // Random numbers and model rules
  // **********************************************************
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Config takes both directions, status and data are read only
  function automatic logic access_legal(input logic wr, input apb_addr_t addr);
    if (addr == ADDR_BIT_CR0 || addr == ADDR_BIT_CR1 || addr == ADDR_DATA_CR) begin
      return 1'b1;
    end
    if (addr == ADDR_DATA_SR || addr == ADDR_ERROR_SR || addr == ADDR_RX_DATA) begin
      return !wr;
    end
    return 1'b0;
  endfunction

  function automatic apb_data_t expected_read(input apb_addr_t addr);
    case (addr)
      ADDR_DATA_SR:  return {7'd0, m_ready};
      ADDR_ERROR_SR: return {6'd0, m_err};
      ADDR_BIT_CR0:  return m_bit_period[7:0];
      ADDR_BIT_CR1:  return {2'd0, m_bit_period[13:8]};
      ADDR_DATA_CR:  return {4'd0, m_data_size};
      ADDR_RX_DATA:  return m_rx;
      default:       return 8'h00;
    endcase
  endfunction

  // **********************************************************
  // Compare tasks
  // **********************************************************
  task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %0t: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit_period(input bit_period_t got, input bit_period_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %0t: bit_period is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_data_size(input data_size_t got, input data_size_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %0t: data_size is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_pulse(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %0t: data_read %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // **********************************************************
  // Bus and UART drivers
  // **********************************************************
  // Setup and access cycle, response sampled at mid-cycle
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    @(posedge tb_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(negedge tb_clk);
    check_err(pslverr, 1'b0, "pslverr in setup cycle");
    check_data(prdata, 8'h00, "prdata in setup cycle");
    check_pulse(data_read, 1'b0, "in setup cycle");
    @(posedge tb_clk);
    penable <= 1'b1;
    @(negedge tb_clk);
    rdata = prdata;
    err   = pslverr;
    check_pulse(data_read, 1'b0, "in access cycle");
    @(posedge tb_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Late pulse search, only entered when the pulse was missed
  task automatic wait_data_read();
    int unsigned waited;
    waited = 0;
    while (data_read !== 1'b1 && waited < PULSE_TIMEOUT) begin
      @(negedge tb_clk);
      waited++;
    end
    if (data_read !== 1'b1) begin
      timeout_errors++;
      $display("Timeout: no data_read pulse within %0d cycles of a receive data read",
               PULSE_TIMEOUT);
    end
  endtask

  task automatic bus_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata);
    apb_data_t rdata;
    logic      err;
    logic      legal;
    legal = access_legal(wr, addr);
    apb_access(wr, addr, wdata, rdata, err);
    check_err(err, !legal, $sformatf("pslverr at address %0d", addr));
    if (!wr) begin
      check_data(rdata, legal ? expected_read(addr) : 8'h00,
                 $sformatf("prdata at address %0d", addr));
    end
    // Slicing rules, upper bus bits that do not fit are dropped
    if (wr && legal) begin
      case (addr)
        ADDR_BIT_CR0: m_bit_period[7:0]  = wdata;
        ADDR_BIT_CR1: m_bit_period[13:8] = wdata[5:0];
        default:      m_data_size        = wdata[3:0];
      endcase
    end
    // Cycle after the access
    @(negedge tb_clk);
    check_bit_period(bit_period, m_bit_period);
    check_data_size(data_size, m_data_size);
    if (!wr && legal && addr == ADDR_RX_DATA) begin
      check_pulse(data_read, 1'b1, "after receive data read");
      if (data_read !== 1'b1) begin
        wait_data_read();
      end
    end else begin
      check_pulse(data_read, 1'b0, "after other access");
    end
  endtask

  // Refused access, then a legal read that must see no pslverr
  task automatic refused_then_legal(input logic wr, input apb_addr_t addr);
    logic [31:0] r;
    r = next_rand();
    bus_transfer(wr, addr, r[31:24]);
    bus_transfer(1'b0, r[23] ? ADDR_BIT_CR1 : ADDR_DATA_CR, 8'h00);
  endtask

  task automatic drive_uart(input logic [31:0] r);
    @(posedge tb_clk);
    data_ready    <= r[31];
    framing_error <= r[30];
    overrun_error <= r[29];
    rx_data       <= r[23:16];
    // Framing first, then overrun
    m_ready = r[31];
    m_err   = r[30] ? 2'd1 : (r[29] ? 2'd2 : 2'd0);
    m_rx    = r[23:16];
    @(negedge tb_clk);
    check_pulse(data_read, 1'b0, "while UART inputs change");
  endtask

  // **********************************************************
  // Test sequence
  // **********************************************************
  initial begin : stimulus
    logic [31:0] r;
    apb_addr_t   addr;
    int unsigned assert_errors;
    lcg_state      = 32'h265b_4daf;
    value_errors   = 0;
    timeout_errors = 0;
    m_bit_period   = 14'd10;
    m_data_size    = 4'd8;
    m_rx           = 8'h00;
    m_ready        = 1'b0;
    m_err          = 2'd0;
    // Reset with every receiver flag held active
    rst_n         <= 1'b0;
    psel          <= 1'b0;
    penable       <= 1'b0;
    pwrite        <= 1'b0;
    paddr         <= 3'd0;
    pwdata        <= 8'h00;
    rx_data       <= 8'hff;
    data_ready    <= 1'b1;
    overrun_error <= 1'b1;
    framing_error <= 1'b1;
    repeat (3) @(posedge tb_clk);
    // Last reset cycle carries the setup of an error status read
    psel          <= 1'b1;
    paddr         <= ADDR_ERROR_SR;
    @(posedge tb_clk);
    // Its access cycle is the first cycle out of reset
    rst_n         <= 1'b1;
    penable       <= 1'b1;
    rx_data       <= 8'h00;
    data_ready    <= 1'b0;
    overrun_error <= 1'b0;
    framing_error <= 1'b0;
    @(negedge tb_clk);
    check_err(pslverr, 1'b0, "pslverr on first read after reset");
    check_data(prdata, 8'h00, "error status on first read after reset");
    check_bit_period(bit_period, m_bit_period);
    check_data_size(data_size, m_data_size);
    check_pulse(data_read, 1'b0, "after reset");
    @(posedge tb_clk);
    psel          <= 1'b0;
    penable       <= 1'b0;
    bus_transfer(1'b0, ADDR_DATA_SR, 8'h00);
    bus_transfer(1'b0, ADDR_ERROR_SR, 8'h00);

    // Config writes with read back
    repeat (40) begin
      r    = next_rand();
      addr = r[31] ? ADDR_DATA_CR : (r[30] ? ADDR_BIT_CR1 : ADDR_BIT_CR0);
      bus_transfer(1'b1, addr, r[23:16]);
      bus_transfer(1'b0, addr, 8'h00);
    end

    // Status reads after random receiver levels
    repeat (30) begin
      drive_uart(next_rand());
      bus_transfer(1'b0, ADDR_DATA_SR, 8'h00);
      bus_transfer(1'b0, ADDR_ERROR_SR, 8'h00);
      bus_transfer(1'b0, ADDR_RX_DATA, 8'h00);
    end

    // Slave errors
    refused_then_legal(1'b1, ADDR_DATA_SR);
    refused_then_legal(1'b1, ADDR_ERROR_SR);
    refused_then_legal(1'b1, ADDR_RX_DATA);
    refused_then_legal(1'b1, 3'd5);
    refused_then_legal(1'b0, 3'd5);
    refused_then_legal(1'b1, 3'd7);
    refused_then_legal(1'b0, 3'd7);

    // Mixed traffic over the whole map
    repeat (150) begin
      r = next_rand();
      if (r[31:29] == 3'd0) begin
        drive_uart(next_rand());
      end
      bus_transfer(r[27], r[26:24], r[23:16]);
    end
    @(negedge tb_clk);
    check_pulse(data_read, 1'b0, "after last access");

    assert_errors = DUT.u_checker.fail_count;
    $display("Errors: %0d value, %0d timeout, %0d assertion",
             value_errors, timeout_errors, assert_errors);
    if (value_errors + timeout_errors + assert_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Hang guard for the whole run
  initial begin : watchdog
    for (int unsigned n = 0; n < WATCHDOG_CYCLES; n++) begin
      @(posedge tb_clk);
    end
    $display("Run stopped after %0d cycles without reaching the end", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
logic/apb_bus_pkg.sv
logic/uart_cfg_pkg.sv
logic/apb_slave_port.sv
logic/uart_config_regs.sv
logic/uart_status_capture.sv
logic/apb_uart_regs.sv
bench/apb_uart_regs_checker.sv
bench/tb_apb_uart_regs.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the APB UART register testbench with Verilator.
# Exits 0 only when the simulation log holds the pass message.

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_apb_uart_regs \
  -Mdir "$OBJ_DIR" \
  -f flist.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

"./$OBJ_DIR/Vtb_apb_uart_regs" +verilator+error+limit+100 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$SIM_LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail, see $SIM_LOG"
exit 1
